// File: lcd_bus_timer.sv
////////////////////////////////////////////////////////////////////////////
// i8080 LCD controller, WR phase timer driving the panel pins
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "lcd_defines.svh"

module lcd_bus_timer (
  input  wire                     aclk,
  input  wire                     arstn,
  input  wire lcd_pkg::lcd_cfg_t  cfg,
  input  wire                     beat_strobe,
  input  wire lcd_pkg::lcd_beat_t beat,
  output logic                    bus_busy,
  output logic                    wr,
  output logic                    dc,
  output logic                    oe,
  output logic [`LCD_BUS_W-1:0]   dout
);

  logic [7:0] phase_cnt;
  logic [7:0] phase_end;

  assign phase_end = wr ? cfg.wr_1_len : cfg.wr_0_len;

  always_ff @(posedge aclk or negedge arstn) begin
    if (!arstn) begin
      bus_busy  <= 1'b0;
      wr        <= 1'b1;
      dc        <= 1'b1;
      oe        <= 1'b0;
      phase_cnt <= '0;
    end else if (beat_strobe) begin
      bus_busy  <= 1'b1;
      wr        <= 1'b0;  // low phase starts next cycle
      dc        <= beat.dc;
      oe        <= 1'b1;
      phase_cnt <= '0;
    end else if (bus_busy) begin
      if (phase_cnt != phase_end) begin
        phase_cnt <= phase_cnt + 8'd1;
      end else begin
        phase_cnt <= '0;
        if (!wr) begin
          wr <= 1'b1;  // panel latches on this edge
        end else begin
          bus_busy <= 1'b0;
          dc       <= 1'b1;
          oe       <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (beat_strobe)
      dout <= beat.data;
  end

  // data and DC must settle before WR goes low and hold until it rises
  assert property (@(posedge aclk) disable iff (!arstn)
    (!wr ##1 !wr) |-> ($stable(dout) && $stable(dc)))
    else $error("panel data changed during WR low");

endmodule

`default_nettype wire

// File: lcd_cmd_seq.sv
////////////////////////////////////////////////////////////////////////////
// i8080 LCD controller, command sequencer
// pops commands, unpacks data words into beats, handles sync ops
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "lcd_defines.svh"

module lcd_cmd_seq (
  input  wire                    aclk,
  input  wire                    arstn,
  input  wire lcd_pkg::lcd_cfg_t cfg,
  input  wire lcd_pkg::lcd_cmd_t cmd_dout,
  input  wire                    cmd_empty,
  output logic                   cmd_pop,
  input  wire [31:0]             data_dout,
  input  wire                    data_empty,
  output logic                   data_pop,
  output logic                   te_arm,
  input  wire                    te_go,
  input  wire                    bus_busy,
  output logic                   beat_strobe,
  output lcd_pkg::lcd_beat_t     beat,
  output logic                   int_strb
);
  import lcd_pkg::*;

  typedef enum logic [2:0] {idle, wait_data, send, wait_te, drain} state_t;

  state_t                state;
  logic [31:0]           word;
  logic [1:0]            byte_idx;
  logic [1:0]            next_idx;
  logic [1:0]            step;
  logic [23:0]           count;
  logic [23:0]           sent;
  logic [23:0]           sent_next;
  logic                  dc_q;
  logic                  single;    // one beat from the command word
  logic                  bus_free;
  logic [`LCD_BUS_W-1:0] lane;

  assign step      = (cfg.bus_bytes == 2'd2) ? 2'd2 : 2'd1;
  assign next_idx  = byte_idx + step;
  assign sent_next = sent + 24'(step);
  assign bus_free  = !bus_busy && !beat_strobe;  // busy lags the strobe by one
  assign cmd_pop   = (state == idle) && !cmd_empty;
  assign data_pop  = (state == wait_data) && !data_empty;

  // low bytes go out first
  always_comb begin
    if (single)
      lane = word[15:0];
    else if (step == 2'd2)
      lane = byte_idx[1] ? word[31:16] : word[15:0];
    else
      lane = {8'h00, word[8*byte_idx +: 8]};
  end

  always_ff @(posedge aclk) begin
    if (cmd_pop)
      word <= {16'h0000, cmd_dout.arg[15:0]};
    else if (data_pop)
      word <= data_dout;
    if (state == send && bus_free)
      beat <= '{data: lane, dc: dc_q};
  end

  always_ff @(posedge aclk or negedge arstn) begin
    if (!arstn) begin
      state       <= idle;
      beat_strobe <= 1'b0;
      te_arm      <= 1'b0;
      int_strb    <= 1'b0;
      count       <= '0;
      sent        <= '0;
      byte_idx    <= '0;
      dc_q        <= 1'b1;
      single      <= 1'b0;
    end else begin
      beat_strobe <= 1'b0;
      te_arm      <= 1'b0;
      int_strb    <= 1'b0;
      case (state)
        idle: begin
          if (!cmd_empty) begin
            sent     <= '0;
            byte_idx <= '0;
            count    <= cmd_dout.arg;
            dc_q     <= (cmd_dout.op != op_write_cmd);
            single   <= (cmd_dout.op != op_write_n);
            case (cmd_dout.op)
              op_write_cmd, op_write_param: state <= send;
              op_write_n: begin
                if (cmd_dout.arg != '0)  // zero count sends nothing
                  state <= wait_data;
              end
              default: begin  // sync
                if (cmd_dout.arg[1]) begin
                  te_arm <= 1'b1;
                  state  <= wait_te;
                end else begin
                  int_strb <= cmd_dout.arg[0];
                end
              end
            endcase
          end
        end
        wait_data: begin
          if (!data_empty)
            state <= send;
        end
        send: begin
          if (bus_free) begin
            beat_strobe <= 1'b1;
            sent        <= sent_next;
            byte_idx    <= next_idx;
            if (single || sent_next >= count)
              state <= drain;
            else if (next_idx == 2'd0)
              state <= wait_data;  // word used up
          end
        end
        wait_te: begin
          if (te_go)
            state <= idle;
        end
        drain: begin
          if (bus_free)
            state <= idle;
        end
        default: state <= idle;
      endcase
    end
  end

  // the bus timer accepts a beat only while idle
  assert property (@(posedge aclk) disable iff (!arstn) beat_strobe |-> !bus_busy)
    else $error("beat strobe while bus busy");

endmodule

`default_nettype wire

// File: lcd_defines.svh
////////////////////////////////////////////////////////////////////////////
// i8080 LCD controller, register map and build constants
////////////////////////////////////////////////////////////////////////////
`ifndef LCD_DEFINES_SVH
`define LCD_DEFINES_SVH

// register byte offsets
`define LCD_VERSION_OFS    8'h00
`define LCD_CFG0_OFS       8'h04
`define LCD_CFG1_OFS       8'h08
`define LCD_CMD_FIFO_OFS   8'h10
`define LCD_DATA_FIFO_OFS  8'h14
`define LCD_CSN_OFS        8'h18

`define LCD_VERSION        32'h80230125

// 4 entries per FIFO
`define LCD_FIFO_AW        2

// panel data pins
`define LCD_BUS_W          16

`endif

// File: lcd_fifo.sv
////////////////////////////////////////////////////////////////////////////
// i8080 LCD controller, synchronous FIFO with a typed payload
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "lcd_defines.svh"

module lcd_fifo #(
  parameter type payload_t = logic [31:0],
  parameter int  aw        = `LCD_FIFO_AW
) (
  input  wire           aclk,
  input  wire           arstn,
  input  wire           push,
  input  wire payload_t din,
  output logic          full,
  input  wire           pop,
  output payload_t      dout,
  output logic          empty
);

  localparam int depth = 1 << aw;

  payload_t      mem [depth];
  logic [aw-1:0] wr_ptr;
  logic [aw-1:0] rd_ptr;
  logic [aw:0]   count;

  assign full  = (count == (aw+1)'(depth));
  assign empty = (count == '0);
  assign dout  = mem[rd_ptr];  // head word, valid while not empty

  always_ff @(posedge aclk) begin
    if (push)
      mem[wr_ptr] <= din;
  end

  always_ff @(posedge aclk or negedge arstn) begin
    if (!arstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // producer and consumer both have to respect the flags
  assert property (@(posedge aclk) disable iff (!arstn) !(push && full) && !(pop && empty))
    else $error("fifo overflow or underflow");

endmodule

`default_nettype wire

// File: lcd_i8080_top.sv
////////////////////////////////////////////////////////////////////////////
// i8080 LCD controller, top level
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "lcd_defines.svh"

module lcd_i8080_top (
  input  wire                       aclk,
  input  wire                       arstn,
  input  wire                       reg_wr_en,
  input  wire lcd_pkg::lcd_reg_req_t reg_wr,
  output logic                      reg_wr_ack,
  input  wire                       reg_rd_en,
  input  wire [7:0]                 reg_rd_addr,
  output logic [31:0]               reg_rd_data,
  output logic                      reg_rd_ack,
  input  wire                       te,
  output logic                      lcd_rst_n,
  output logic                      csn,
  output logic                      wr,
  output logic                      dc,
  output logic                      oe,
  output logic [`LCD_BUS_W-1:0]     dout,
  output logic                      int_strb,
  output logic                      data_fifo_ready
);
  import lcd_pkg::*;

  lcd_cfg_t    cfg;
  lcd_cmd_t    cmd_din, cmd_dout;
  logic [31:0] data_din, data_dout;
  logic        cmd_push, cmd_full, cmd_pop, cmd_empty;
  logic        data_push, data_full, data_pop, data_empty;
  logic        te_arm, te_go;
  logic        bus_busy, beat_strobe;
  lcd_beat_t   beat;

  assign lcd_rst_n       = cfg.lcd_rst;
  assign data_fifo_ready = !data_full;

  lcd_regs u_regs (
    .aclk, .arstn, .reg_wr_en, .reg_wr, .reg_wr_ack,
    .reg_rd_en, .reg_rd_addr, .reg_rd_data, .reg_rd_ack,
    .cfg, .csn, .cmd_push, .cmd_din, .data_push, .data_din,
    .cmd_full, .data_full
  );

  lcd_fifo #(.payload_t(lcd_cmd_t)) cmd_fifo (
    .aclk, .arstn, .push(cmd_push), .din(cmd_din), .full(cmd_full),
    .pop(cmd_pop), .dout(cmd_dout), .empty(cmd_empty)
  );

  lcd_fifo #(.payload_t(logic [31:0])) data_fifo (
    .aclk, .arstn, .push(data_push), .din(data_din), .full(data_full),
    .pop(data_pop), .dout(data_dout), .empty(data_empty)
  );

  lcd_te_sync u_te_sync (
    .aclk, .arstn, .te, .te_arm, .te_delay(cfg.te_delay), .te_go
  );

  lcd_cmd_seq u_cmd_seq (
    .aclk, .arstn, .cfg, .cmd_dout, .cmd_empty, .cmd_pop,
    .data_dout, .data_empty, .data_pop, .te_arm, .te_go,
    .bus_busy, .beat_strobe, .beat, .int_strb
  );

  lcd_bus_timer u_bus_timer (
    .aclk, .arstn, .cfg, .beat_strobe, .beat, .bus_busy,
    .wr, .dc, .oe, .dout
  );

endmodule

`default_nettype wire

// File: lcd_pkg.sv
////////////////////////////////////////////////////////////////////////////
// i8080 LCD controller, shared struct and enum types
////////////////////////////////////////////////////////////////////////////
`default_nettype none

`include "lcd_defines.svh"

package lcd_pkg;

  typedef struct packed {
    logic [7:0]  wr_0_len;   // WR low cycles minus one
    logic [7:0]  wr_1_len;   // WR high cycles minus one
    logic [1:0]  bus_bytes;  // 1 = 8 bit, 2 = 16 bit
    logic [15:0] te_delay;
    logic        lcd_rst;    // drives the panel reset pin
  } lcd_cfg_t;

  typedef enum logic [1:0] {
    op_write_cmd   = 2'd0,
    op_write_param = 2'd1,
    op_write_n     = 2'd2,
    op_sync        = 2'd3
  } lcd_op_e;

  // arg holds byte count, single write value, or sync flags {te, int}
  typedef struct packed {
    lcd_op_e     op;
    logic [5:0]  rsvd;
    logic [23:0] arg;
  } lcd_cmd_t;

  typedef struct packed {
    logic [`LCD_BUS_W-1:0] data;
    logic                  dc;
  } lcd_beat_t;

  typedef struct packed {
    logic [7:0]  addr;
    logic [31:0] data;
  } lcd_reg_req_t;

endpackage

`default_nettype wire

// File: lcd_regs.sv
////////////////////////////////////////////////////////////////////////////
// i8080 LCD controller, host register file
// config and chip select storage, readback, FIFO pushes with ack stall
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "lcd_defines.svh"

module lcd_regs (
  input  wire                       aclk,
  input  wire                       arstn,
  input  wire                       reg_wr_en,
  input  wire lcd_pkg::lcd_reg_req_t reg_wr,
  output logic                      reg_wr_ack,
  input  wire                       reg_rd_en,
  input  wire [7:0]                 reg_rd_addr,
  output logic [31:0]               reg_rd_data,
  output logic                      reg_rd_ack,
  output lcd_pkg::lcd_cfg_t         cfg,
  output logic                      csn,
  output logic                      cmd_push,
  output lcd_pkg::lcd_cmd_t         cmd_din,
  output logic                      data_push,
  output logic [31:0]               data_din,
  input  wire                       cmd_full,
  input  wire                       data_full
);
  import lcd_pkg::*;

  logic [7:0] wr_ofs;
  logic [7:0] rd_ofs;

  assign wr_ofs = {reg_wr.addr[7:2], 2'b00};  // word aligned
  assign rd_ofs = {reg_rd_addr[7:2], 2'b00};

  assign cmd_din   = lcd_cmd_t'(reg_wr.data);
  assign data_din  = reg_wr.data;
  assign cmd_push  = reg_wr_en && (wr_ofs == `LCD_CMD_FIFO_OFS) && !cmd_full;
  assign data_push = reg_wr_en && (wr_ofs == `LCD_DATA_FIFO_OFS) && !data_full;

  // FIFO writes hold off while full, everything else acks at once
  always_comb begin
    reg_wr_ack = 1'b0;
    if (reg_wr_en) begin
      case (wr_ofs)
        `LCD_CMD_FIFO_OFS:  reg_wr_ack = !cmd_full;
        `LCD_DATA_FIFO_OFS: reg_wr_ack = !data_full;
        default:            reg_wr_ack = 1'b1;
      endcase
    end
  end

  always_ff @(posedge aclk or negedge arstn) begin
    if (!arstn) begin
      cfg.wr_0_len  <= '0;
      cfg.wr_1_len  <= '0;
      cfg.bus_bytes <= 2'd1;  // 8 bit bus
      cfg.te_delay  <= '0;
      cfg.lcd_rst   <= 1'b0;  // panel held in reset
      csn           <= 1'b1;
    end else if (reg_wr_en) begin
      case (wr_ofs)
        `LCD_CFG0_OFS: begin
          cfg.wr_0_len <= reg_wr.data[7:0];
          cfg.wr_1_len <= reg_wr.data[15:8];
        end
        `LCD_CFG1_OFS: begin
          cfg.te_delay  <= reg_wr.data[31:16];
          cfg.lcd_rst   <= reg_wr.data[4];
          cfg.bus_bytes <= reg_wr.data[1:0];
        end
        `LCD_CSN_OFS: csn <= reg_wr.data[0];
        default: ;
      endcase
    end
  end

  assign reg_rd_ack = reg_rd_en;

  always_comb begin
    reg_rd_data = '0;
    if (reg_rd_en) begin
      case (rd_ofs)
        `LCD_VERSION_OFS: reg_rd_data = `LCD_VERSION;
        `LCD_CFG0_OFS:    reg_rd_data = {16'h0000, cfg.wr_1_len, cfg.wr_0_len};
        `LCD_CFG1_OFS:    reg_rd_data = {cfg.te_delay, 11'h000, cfg.lcd_rst,
                                         2'b00, cfg.bus_bytes};
        `LCD_CSN_OFS:     reg_rd_data = {31'h0, csn};
        default:          reg_rd_data = '0;  // FIFO ports are write only
      endcase
    end
  end

endmodule

`default_nettype wire

// File: lcd_te_sync.sv
////////////////////////////////////////////////////////////////////////////
// i8080 LCD controller, TE synchronizer with armed edge and delay
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module lcd_te_sync (
  input  wire        aclk,
  input  wire        arstn,
  input  wire        te,
  input  wire        te_arm,
  input  wire [15:0] te_delay,
  output logic       te_go
);

  logic [2:0]  te_q;       // [1] is the synchronized level
  logic        te_rise;
  logic        armed;
  logic        counting;
  logic [15:0] delay_cnt;

  assign te_rise = te_q[1] & ~te_q[2];
  assign te_go   = counting && (delay_cnt == '0);

  always_ff @(posedge aclk or negedge arstn) begin
    if (!arstn) begin
      te_q      <= '0;
      armed     <= 1'b0;
      counting  <= 1'b0;
      delay_cnt <= '0;
    end else begin
      te_q <= {te_q[1:0], te};
      if (te_arm) begin
        armed <= 1'b1;  // earlier edges are ignored
      end else if (armed && te_rise) begin
        armed     <= 1'b0;
        counting  <= 1'b1;
        delay_cnt <= te_delay;
      end else if (counting) begin
        if (delay_cnt == '0)
          counting <= 1'b0;
        else
          delay_cnt <= delay_cnt - 16'd1;
      end
    end
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+.
lcd_pkg.sv
lcd_fifo.sv
lcd_regs.sv
lcd_te_sync.sv
lcd_cmd_seq.sv
lcd_bus_timer.sv
lcd_i8080_top.sv
tb_lcd_i8080.sv

// File: tb_lcd_i8080.sv
////////////////////////////////////////////////////////////////////////////
// i8080 LCD controller testbench
// table of register writes, TE pulses and expected panel beats
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "lcd_defines.svh"

module tb_lcd_i8080;
  import lcd_pkg::*;

  typedef enum {k_wr, k_rd, k_beat, k_te, k_full, k_quiet, k_int, k_rdy} row_kind_e;

  typedef struct {
    row_kind_e   kind;
    logic [7:0]  ofs;
    logic [31:0] data;   // write value, read value, or {dc, beat data}
  } row_t;

  logic                  aclk;
  logic                  arstn;
  logic                  reg_wr_en;
  lcd_reg_req_t          reg_wr;
  logic                  reg_wr_ack;
  logic                  reg_rd_en;
  logic [7:0]            reg_rd_addr;
  logic [31:0]           reg_rd_data;
  logic                  reg_rd_ack;
  logic                  te;
  logic                  lcd_rst_n;
  logic                  csn;
  logic                  wr;
  logic                  dc;
  logic                  oe;
  logic [`LCD_BUS_W-1:0] dout;
  logic                  int_strb;
  logic                  data_fifo_ready;

  row_t        rows [$];
  lcd_beat_t   beat_q [$];  // filled by the bus monitor
  int          low_q [$];
  int          high_q [$];
  int          start_q [$];
  lcd_beat_t   cur_beat;
  int          cur_low;
  int          cur_start;
  int          low_cnt = 0;
  int          high_cnt = 0;
  int          int_cnt = 0;
  logic        prev_wr = 1'b1;
  logic        prev_oe = 1'b0;
  int          cyc = 0;
  int          cycle_limit = 100000;
  int          max_beat = 2;
  int          exp_wr0 = 0;
  int          exp_wr1 = 0;
  int          exp_te_delay = 0;
  int          te_cyc = 0;
  logic        te_pending = 1'b0;
  int          checks = 0;
  int          beat_errs = 0;
  int          word_errs = 0;
  int          len_errs = 0;
  int          other_errs = 0;

  lcd_i8080_top uut (
    .aclk, .arstn, .reg_wr_en, .reg_wr, .reg_wr_ack,
    .reg_rd_en, .reg_rd_addr, .reg_rd_data, .reg_rd_ack,
    .te, .lcd_rst_n, .csn, .wr, .dc, .oe, .dout, .int_strb, .data_fifo_ready
  );

  always #50 aclk = ~aclk;

  task automatic report_counts();
    $display("checks %0d, errors: beat %0d, word %0d, len %0d, other %0d",
             checks, beat_errs, word_errs, len_errs, other_errs);
  endtask

  // watchdog
  always @(posedge aclk) begin
    cyc = cyc + 1;
    if (cyc > cycle_limit) begin
      other_errs++;
      $display("error at %0d ns: run did not finish within %0d cycles", $time, cycle_limit);
      report_counts();
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // bus monitor sampled mid cycle where the pins are stable
  always @(negedge aclk) begin
    if (int_strb)
      int_cnt++;
    if (!wr) begin
      if (prev_wr)
        cur_start = cyc;  // WR falling
      low_cnt++;
    end
    if (wr && !prev_wr) begin
      cur_beat.data = dout;  // panel latches here
      cur_beat.dc   = dc;
      cur_low       = low_cnt;
      low_cnt       = 0;
      high_cnt      = 1;
    end else if (wr && oe) begin
      high_cnt++;
    end
    if (!oe && prev_oe) begin
      beat_q.push_back(cur_beat);
      low_q.push_back(cur_low);
      high_q.push_back(high_cnt);
      start_q.push_back(cur_start);
    end
    prev_wr = wr;
    prev_oe = oe;
  end

  task automatic compare_beat(input string name, input lcd_beat_t got, input lcd_beat_t exp);
    checks++;
    if (got !== exp) begin
      beat_errs++;
      $display("error at %0d ns: %s got data %h dc %b, expected data %h dc %b",
               $time, name, got.data, got.dc, exp.data, exp.dc);
    end
  endtask

  task automatic compare_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      word_errs++;
      $display("error at %0d ns: %s got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic compare_len(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      len_errs++;
      $display("error at %0d ns: %s got %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  function automatic void add_row(row_kind_e kind, logic [7:0] ofs, logic [31:0] data);
    row_t r;
    r.kind = kind;
    r.ofs  = ofs;
    r.data = data;
    rows.push_back(r);
    if (kind == k_wr && ofs == `LCD_CFG0_OFS && int'(data[7:0]) + int'(data[15:8]) + 2 > max_beat)
      max_beat = int'(data[7:0]) + int'(data[15:8]) + 2;
  endfunction

  function automatic void expect_beat(logic [15:0] d, logic dc_val);
    add_row(k_beat, 8'h00, {15'h0000, dc_val, d});
  endfunction

  function automatic logic [31:0] cmd_word(lcd_op_e op, logic [23:0] arg);
    return {op, 6'h00, arg};
  endfunction

  // low bytes first with 1 or 2 bytes per beat
  function automatic void unpack_word(logic [31:0] w, int bpb, int nbytes);
    int b;
    for (b = 0; b < nbytes; b += bpb) begin
      if (bpb == 2)
        expect_beat(w[8*b +: 16], 1'b1);
      else
        expect_beat({8'h00, w[8*b +: 8]}, 1'b1);
    end
  endfunction

  task automatic build_table();
    logic [31:0] w [4];
    int          i;
    add_row(k_rd, `LCD_VERSION_OFS, `LCD_VERSION);
    add_row(k_wr, `LCD_CFG0_OFS, 32'h0000_0102);  // WR low 3, high 2
    add_row(k_rd, `LCD_CFG0_OFS, 32'h0000_0102);
    add_row(k_wr, `LCD_CFG1_OFS, 32'h000c_0011);  // te_delay 12, reset off, 8 bit
    add_row(k_rd, `LCD_CFG1_OFS, 32'h000c_0011);
    add_row(k_wr, `LCD_CSN_OFS, 32'h0);
    add_row(k_rd, `LCD_CSN_OFS, 32'h0);
    // alternating command and parameter writes
    for (i = 0; i < 4; i++) begin
      w[i] = $urandom();
      add_row(k_wr, `LCD_CMD_FIFO_OFS,
              cmd_word(i[0] ? op_write_param : op_write_cmd, {8'h00, w[i][15:0]}));
    end
    for (i = 0; i < 4; i++)
      expect_beat(w[i][15:0], i[0]);
    // write N of 6 bytes on the 8 bit bus
    add_row(k_wr, `LCD_CMD_FIFO_OFS, cmd_word(op_write_n, 24'd6));
    for (i = 0; i < 2; i++) begin
      w[i] = $urandom();
      add_row(k_wr, `LCD_DATA_FIFO_OFS, w[i]);
    end
    unpack_word(w[0], 1, 4);
    unpack_word(w[1], 1, 2);
    // write N of 8 bytes on the 16 bit bus
    add_row(k_wr, `LCD_CFG0_OFS, 32'h0000_0300);  // WR low 1, high 4
    add_row(k_wr, `LCD_CFG1_OFS, 32'h000c_0012);
    add_row(k_wr, `LCD_CMD_FIFO_OFS, cmd_word(op_write_n, 24'd8));
    for (i = 0; i < 2; i++) begin
      w[i] = $urandom();
      add_row(k_wr, `LCD_DATA_FIFO_OFS, w[i]);
    end
    unpack_word(w[0], 2, 4);
    unpack_word(w[1], 2, 4);
    // sync on TE with the queued commands waiting behind it
    add_row(k_wr, `LCD_CMD_FIFO_OFS, cmd_word(op_sync, 24'h2));
    for (i = 0; i < 4; i++) begin
      w[i] = $urandom();
      add_row(k_wr, `LCD_CMD_FIFO_OFS, cmd_word(op_write_cmd, {8'h00, w[i][15:0]}));
    end
    add_row(k_full, `LCD_CMD_FIFO_OFS, cmd_word(op_write_cmd, 24'h00a5));
    add_row(k_quiet, 8'h00, 32'h0);
    add_row(k_te, 8'h00, 32'h0);
    for (i = 0; i < 4; i++)
      expect_beat(w[i][15:0], 1'b0);
    // interrupt sync then a data FIFO fill with no consumer
    add_row(k_wr, `LCD_CMD_FIFO_OFS, cmd_word(op_sync, 24'h1));
    add_row(k_int, 8'h00, 32'd1);
    for (i = 0; i < 4; i++) begin
      add_row(k_wr, `LCD_DATA_FIFO_OFS, $urandom());
      if (i == 2)
        add_row(k_rdy, 8'h00, 32'd1);
    end
    add_row(k_rdy, 8'h00, 32'd0);
    add_row(k_full, `LCD_DATA_FIFO_OFS, $urandom());
    add_row(k_quiet, 8'h00, 32'h0);
  endtask

  // all bus tasks start and end 5 ns after a rising edge
  task automatic write_reg(input logic [7:0] ofs, input logic [31:0] value);
    reg_wr_en   = 1'b1;
    reg_wr.addr = ofs;
    reg_wr.data = value;
    @(negedge aclk);
    while (!reg_wr_ack)
      @(negedge aclk);
    @(posedge aclk);
    #5;
    reg_wr_en = 1'b0;
  endtask

  task automatic read_reg(input logic [7:0] ofs, output logic [31:0] value);
    reg_rd_en   = 1'b1;
    reg_rd_addr = ofs;
    @(negedge aclk);
    if (!reg_rd_ack) begin
      other_errs++;
      $display("error at %0d ns: read of offset %h was not acknowledged", $time, ofs);
    end
    value = reg_rd_data;
    @(posedge aclk);
    #5;
    reg_rd_en = 1'b0;
  endtask

  task automatic apply_row(input row_t r);
    logic [31:0] got;
    lcd_beat_t   exp_beat;
    int          st;
    case (r.kind)
      k_wr: begin
        write_reg(r.ofs, r.data);
        if (r.ofs == `LCD_CFG0_OFS) begin
          exp_wr0 = r.data[7:0];
          exp_wr1 = r.data[15:8];
        end else if (r.ofs == `LCD_CFG1_OFS) begin
          exp_te_delay = r.data[31:16];
        end
      end
      k_rd: begin
        read_reg(r.ofs, got);
        compare_word("reg_rd_data", got, r.data);
      end
      k_beat: begin
        while (beat_q.size() == 0)
          @(negedge aclk);
        exp_beat.data = r.data[`LCD_BUS_W-1:0];
        exp_beat.dc   = r.data[`LCD_BUS_W];
        compare_beat("dout/dc", beat_q.pop_front(), exp_beat);
        compare_len("wr low width", low_q.pop_front(), exp_wr0 + 1);
        compare_len("wr high width", high_q.pop_front(), exp_wr1 + 1);
        st = start_q.pop_front();
        if (te_pending) begin
          te_pending = 1'b0;
          checks++;
          if (st - te_cyc < exp_te_delay) begin
            len_errs++;
            $display("error at %0d ns: te to beat gap got %0d, expected at least %0d",
                     $time, st - te_cyc, exp_te_delay);
          end
        end
        @(posedge aclk);
        #5;
      end
      k_te: begin
        te         = 1'b1;
        te_cyc     = cyc;
        te_pending = 1'b1;
        repeat (4) @(posedge aclk);
        #5;
        te = 1'b0;
      end
      k_full: begin  // write must stall while the FIFO is full
        reg_wr_en   = 1'b1;
        reg_wr.addr = r.ofs;
        reg_wr.data = r.data;
        repeat (10) begin
          @(negedge aclk);
          if (reg_wr_ack) begin
            other_errs++;
            $display("error at %0d ns: write to offset %h acknowledged while FIFO full",
                     $time, r.ofs);
          end
        end
        @(posedge aclk);
        #5;
        reg_wr_en = 1'b0;
      end
      k_quiet: begin
        repeat (10) @(posedge aclk);
        #5;
        if (beat_q.size() != 0 || oe) begin
          other_errs++;
          $display("error at %0d ns: panel beat seen while none was expected", $time);
        end
      end
      k_int: begin
        repeat (8) @(posedge aclk);
        #5;
        compare_len("int_strb pulses", int_cnt, int'(r.data));
      end
      k_rdy: begin
        @(negedge aclk);
        compare_word("data_fifo_ready", 32'(data_fifo_ready), r.data);
        @(posedge aclk);
        #5;
      end
      default: ;
    endcase
  endtask

  initial begin
    aclk        = 1'b0;
    arstn       = 1'b0;
    reg_wr_en   = 1'b0;
    reg_wr      = '0;
    reg_rd_en   = 1'b0;
    reg_rd_addr = '0;
    te          = 1'b0;
    void'($urandom(99));
    build_table();
    cycle_limit = 40 * rows.size() * max_beat;
    repeat (2) @(posedge aclk);
    #5;
    arstn = 1'b1;
    // panel pins idle out of reset
    @(negedge aclk);
    compare_word("wr", 32'(wr), 32'h1);
    compare_word("dc", 32'(dc), 32'h1);
    compare_word("oe", 32'(oe), 32'h0);
    compare_word("csn", 32'(csn), 32'h1);
    compare_word("lcd_rst_n", 32'(lcd_rst_n), 32'h0);
    @(posedge aclk);
    #5;
    foreach (rows[i])
      apply_row(rows[i]);
    report_counts();
    if (beat_errs + word_errs + len_errs + other_errs == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire
